//--- project.f
design/forth_pkg.sv
design/text_mem.sv
design/token_scan.sv
design/atoi.sv
design/number_parser.sv
test/tb_number_parser.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f project.f --top-module tb_number_parser -o sim \
    && ./obj_dir/sim | tee sim.log \
    && grep -qF ">>> PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/tb_number_parser.sv
// directed testbench for the number conversion front end
// text loader, conversion driver, reference parser, random round trips

`timescale 1ns/1ns

module tb_number_parser import forth_pkg::*;;

    logic           clk;
    logic           rst;
    logic           mem_we;
    logic [asz-1:0] mem_waddr;
    logic [7:0]     mem_wdata;
    logic           start;
    logic [asz-1:0] start_addr;
    logic           hex;
    logic           busy;
    logic           done;
    logic [dsz-1:0] value;
    logic [asz-1:0] end_addr;

    int             errors   = 0;               // failed checks
    int             checks   = 0;
    int             starts   = 0;               // accepted start strobes
    int             done_cnt = 0;               // done pulses seen
    bit             stuck    = 1'b0;            // a conversion never finished
    logic [31:0]    seed     = 32'hb5ff_e6f0;

    number_parser u_dut (
        .clk        (clk),
        .rst        (rst),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .start      (start),
        .start_addr (start_addr),
        .hex        (hex),
        .busy       (busy),
        .done       (done),
        .value      (value),
        .end_addr   (end_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    // done pulses counted on the falling edge
    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_cnt++;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;  // numerical recipes LCG
        return seed;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    // digit value of one character or -1
    function automatic int digit_of(input byte c);
        int d;
        d = -1;
        if (c >= "0" && c <= "9") begin
            d = int'(c) - 'h30;
        end else if (c >= "a" && c <= "f") begin
            d = int'(c) - 'h61 + 10;
        end else if (c >= "A" && c <= "F") begin
            d = int'(c) - 'h41 + 10;
        end
        return d;
    endfunction

    // expected value and stop offset for a NUL-terminated token
    function automatic void ref_parse(input string s, input bit hx,
                                      output logic [31:0] v, output int stop);
        int          i;
        int          d;
        int          radix;
        bit          neg;
        bit          going;
        logic [31:0] sum;
        i     = 0;
        neg   = 1'b0;
        sum   = '0;
        radix = hx ? 16 : 10;
        while (i < s.len() && s[i] == " ") begin
            i++;                                // leading blanks only
        end
        if (i < s.len() && s[i] == "-") begin
            neg = 1'b1;
            i++;
        end
        going = 1'b1;
        while (going && i < s.len()) begin
            d = digit_of(s[i]);
            if (d >= 0 && d < radix) begin
                sum = sum * 32'(radix) + 32'(d); // mod 2^32
                i++;
            end else begin
                going = 1'b0;                   // first non-digit ends it
            end
        end
        v    = neg ? -sum : sum;
        stop = i;                               // len() is the NUL
    endfunction

    task automatic load_text(input logic [asz-1:0] base, input string s);
        int i;
        for (i = 0; i <= s.len(); i++) begin
            @(posedge clk);
            mem_we    <= 1'b1;
            mem_waddr <= base + asz'(i);
            mem_wdata <= (i < s.len()) ? 8'(s[i]) : ch_nul;
        end
        @(posedge clk);
        mem_we <= 1'b0;
    endtask

    // one start strobe, optional second strobe while busy, then wait for done
    task automatic convert(input logic [asz-1:0] addr, input bit hx, input bit poke,
                           output bit ok);
        int t;
        @(posedge clk);
        start      <= 1'b1;
        start_addr <= addr;
        hex        <= hx;
        @(posedge clk);
        start <= 1'b0;
        starts++;
        if (poke) begin
            @(negedge clk);
            check("busy during conversion", 32'(busy), 32'd1);
            @(posedge clk);
            start      <= 1'b1;                 // must be ignored
            start_addr <= addr + asz'(1);
            @(posedge clk);
            start <= 1'b0;
        end
        t = 0;
        @(negedge clk);
        while (done !== 1'b1 && t < 200) begin
            @(negedge clk);
            t++;
        end
        ok = (done === 1'b1);
    endtask

    task automatic run_case(input logic [asz-1:0] base, input string s, input bit hx,
                            input bit poke);
        logic [31:0]    exp_v;
        logic [asz-1:0] exp_end;                // stop address wraps with the buffer
        int             stop;
        bit             ok;
        if (!stuck) begin
            load_text(base, s);
            ref_parse(s, hx, exp_v, stop);
            exp_end = base + asz'(stop);
            convert(base, hx, poke, ok);
            if (!ok) begin
                stuck = 1'b1;
                $display("no done from the DUT within 200 cycles for text '%s'", s);
            end else begin
                check($sformatf("value of '%s'", s), value, exp_v);
                check($sformatf("end_addr of '%s'", s), 32'(end_addr), 32'(exp_end));
            end
        end
    endtask

    // random words printed as text and parsed back
    task automatic random_round_trip(input int n);
        logic [31:0] r;
        logic [31:0] ctl;
        logic [31:0] mv;
        int          stop;
        int          i;
        int          k;
        string       txt;
        bit          hx;
        bit          neg;
        for (i = 0; i < n; i++) begin
            r   = next_rand();
            ctl = next_rand();
            hx  = ctl[4];
            neg = ctl[9];
            txt = hx ? $sformatf("%h", r) : $sformatf("%0d", r);
            if (hx) begin
                for (k = 0; k < txt.len(); k++) begin
                    if (txt[k] >= "a" && ctl[16+k]) begin
                        txt[k] = txt[k] - 8'd32;    // upper case
                    end
                end
            end
            if (neg) begin
                txt = {"-", txt};
            end
            for (k = 0; k < int'(ctl[13:12]); k++) begin
                txt = {" ", txt};
            end
            ref_parse(txt, hx, mv, stop);
            check($sformatf("model of '%s'", txt), mv, neg ? -r : r);
            run_case(ctl[31:24], txt, hx, 1'b0);
        end
    endtask

    initial begin
        rst        = 1'b1;
        mem_we     = 1'b0;
        mem_waddr  = '0;
        mem_wdata  = '0;
        start      = 1'b0;
        start_addr = '0;
        hex        = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("busy after reset", 32'(busy), 32'd0);
        check("done after reset", 32'(done), 32'd0);
        check("value after reset", value, 32'd0);

        run_case(8'h00, "12345", 1'b0, 1'b0);   // decimal
        run_case(8'h10, "0", 1'b0, 1'b0);
        run_case(8'h18, "-42", 1'b0, 1'b0);
        run_case(8'h20, "7fFF", 1'b1, 1'b0);    // mixed case hex
        run_case(8'h28, "-DeadBeef", 1'b1, 1'b0);
        run_case(8'h40, "  99x", 1'b0, 1'b0);   // blanks, early stop
        run_case(8'h48, "12 34", 1'b0, 1'b0);
        run_case(8'h50, "   -7g", 1'b1, 1'b0);
        run_case(8'h58, "-", 1'b0, 1'b0);
        run_case(8'h60, "   ", 1'b0, 1'b0);     // blanks up to NUL
        run_case(8'h68, "1a", 1'b0, 1'b0);      // radix limits digits
        run_case(8'h6c, "1a", 1'b1, 1'b0);
        run_case(8'h70, "99999999999", 1'b0, 1'b0);  // wraps
        run_case(8'h80, "123456789abcdef", 1'b1, 1'b0);
        run_case(8'h90, "-42", 1'b0, 1'b1);     // start while busy
        run_case(8'h98, "-ff", 1'b1, 1'b1);
        random_round_trip(24);

        repeat (8) @(negedge clk);              // room for a stray done
        if (!stuck) begin
            check("done pulses per start", 32'(done_cnt), 32'(starts));
        end else begin
            $display("simulation stopped early, a conversion never finished");
        end
        $display("checks %0d, errors %0d, done pulses %0d for %0d starts",
                 checks, errors, done_cnt, starts);
        if (!stuck && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- design/number_parser.sv
// number conversion front end top level
// text buffer, token scanner and converter

`timescale 1ns/1ns

module number_parser import forth_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_we,              // host byte write
    input  logic [asz-1:0] mem_waddr,
    input  logic [7:0]     mem_wdata,
    input  logic           start,               // conversion request strobe
    input  logic [asz-1:0] start_addr,
    input  logic           hex,
    output logic           busy,
    output logic           done,
    output logic [dsz-1:0] value,
    output logic [asz-1:0] end_addr
);

    logic [asz-1:0] rd_addr;                    // scanner owned read pointer
    logic [7:0]     rd_data;
    logic           conv_en;
    logic           conv_busy;
    logic           adv;

    text_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    token_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .start_addr (start_addr),
        .rdata      (rd_data),
        .conv_busy  (conv_busy),
        .adv        (adv),
        .rd_addr    (rd_addr),
        .conv_en    (conv_en),
        .busy       (busy),
        .done       (done),
        .end_addr   (end_addr)
    );

    atoi u_atoi (
        .clk  (clk),
        .rst  (rst),
        .en   (conv_en),
        .hex  (hex),                            // sampled when conversion begins
        .ch   (rd_data),
        .busy (conv_busy),
        .adv  (adv),
        .vo   (value)
    );

endmodule

//--- design/atoi.sv
// signed ASCII to integer converter, one character per two cycles
// decimal or hex radix, optional leading minus, wraps modulo 2^dsz

`timescale 1ns/1ns

module atoi import forth_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           en,                  // conversion enable, level
    input  logic           hex,                 // 1 hex, 0 decimal
    input  logic [7:0]     ch,                  // current character
    output logic           busy,
    output logic           adv,                 // step read address
    output logic [dsz-1:0] vo                   // converted value
);

    atoi_state      st;
    atoi_state      st_nxt;
    logic           neg;                        // minus seen
    logic           hex_r;                      // radix for this token
    logic [3:0]     dig;                        // decoded digit value
    logic           is_dig;                     // ch is 0-9, a-f or A-F
    logic           ok;                         // digit valid in this radix
    logic [dsz-1:0] radix;

    assign radix = hex_r ? dsz'(16) : dsz'(10);

    // character decode
    always_comb begin
        dig    = 4'd0;
        is_dig = 1'b0;
        if (ch >= "0" && ch <= "9") begin
            dig    = 4'(ch - "0");
            is_dig = 1'b1;
        end else if (ch >= "a" && ch <= "f") begin
            dig    = 4'(ch - "a" + 8'd10);
            is_dig = 1'b1;
        end else if (ch >= "A" && ch <= "F") begin
            dig    = 4'(ch - "A" + 8'd10);
            is_dig = 1'b1;
        end
    end

    // letters fail the range test in decimal
    assign ok = is_dig && (ch != ch_nul) && (hex_r || dig < 4'd10);

    // next state
    always_comb begin
        case (st)
            ini:     st_nxt = en ? ((ch == ch_minus) ? mem : acc) : ini;
            mem:     st_nxt = busy ? acc : ini;     // read wait, or wind down
            acc:     st_nxt = mem;
            default: st_nxt = ini;
        endcase
    end

    // address stepping, only past consumed characters
    always_comb begin
        adv = 1'b0;
        case (st)
            ini:     adv = en && (ch == ch_minus);  // skip the sign
            acc:     adv = ok;                      // prefetch next digit
            default: adv = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st    <= ini;
            busy  <= 1'b0;
            neg   <= 1'b0;
            hex_r <= 1'b0;
            vo    <= '0;
        end else begin
            st <= st_nxt;
            case (st)
                ini: begin
                    busy <= en;
                    if (en) begin               // new token
                        neg   <= (ch == ch_minus);
                        hex_r <= hex;
                        vo    <= '0;
                    end
                end
                acc: begin
                    if (ok) begin
                        vo <= vo * radix + dsz'(dig);  // wraps, no overflow check
                    end else begin
                        busy <= 1'b0;           // value final next cycle
                        if (neg) begin
                            vo <= -vo;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- design/token_scan.sv
// token scanner: owns the buffer read address, skips leading spaces,
// runs the converter and flags completion with the stop address

`timescale 1ns/1ns

module token_scan import forth_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,               // request strobe
    input  logic [asz-1:0] start_addr,
    input  logic [7:0]     rdata,               // byte at rd_addr, one cycle late
    input  logic           conv_busy,
    input  logic           adv,                 // converter wants next byte
    output logic [asz-1:0] rd_addr,
    output logic           conv_en,             // level, held while converting
    output logic           busy,
    output logic           done,                // one-cycle strobe
    output logic [asz-1:0] end_addr
);

    scan_state st;
    logic      seen;                            // converter busy has risen
    logic      fin;                             // converter finished this cycle

    // only a converter that has actually started can finish
    assign fin = (st == conv) && seen && !conv_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            st      <= idle;
            rd_addr <= '0;
            conv_en <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            seen    <= 1'b0;
        end else begin
            done <= 1'b0;                       // strobe by default
            case (st)
                idle: begin
                    if (start) begin            // starts while busy never get here
                        rd_addr <= start_addr;
                        busy    <= 1'b1;
                        st      <= fetch;
                    end
                end
                fetch: begin
                    st <= skip;                 // rdata valid next cycle
                end
                skip: begin
                    if (rdata == ch_space) begin
                        rd_addr <= rd_addr + 1'b1;  // step past the blank
                        st      <= fetch;
                    end else begin
                        conv_en <= 1'b1;        // first char of token on rdata
                        seen    <= 1'b0;
                        st      <= conv;
                    end
                end
                conv: begin
                    if (adv) begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                    if (conv_busy) begin
                        seen <= 1'b1;
                    end
                    if (fin) begin
                        conv_en <= 1'b0;        // lets converter settle in ini
                        busy    <= 1'b0;
                        done    <= 1'b1;
                        st      <= idle;
                    end
                end
                default: st <= idle;
            endcase
        end
    end

    // stop address, rd_addr sits on the terminating byte here
    always_ff @(posedge clk) begin
        if (fin) begin
            end_addr <= rd_addr;
        end
    end

endmodule

//--- design/text_mem.sv
// byte-wide text buffer, host write port plus registered read port
// behaves like a simple dual-port block RAM

`timescale 1ns/1ns

module text_mem import forth_pkg::*; (
    input  logic           clk,
    input  logic           we,                  // host write strobe
    input  logic [asz-1:0] waddr,
    input  logic [7:0]     wdata,
    input  logic [asz-1:0] raddr,
    output logic [7:0]     rdata                // one cycle after raddr
);

    logic [7:0] ram [2**asz];                   // line storage

    // host side
    always_ff @(posedge clk) begin
        if (we) begin
            ram[waddr] <= wdata;
        end
    end

    // read side, registered output
    always_ff @(posedge clk) begin
        rdata <= ram[raddr];
    end

endmodule

//--- design/forth_pkg.sv
// shared widths, FSM state encodings and ASCII codes
// for the number-conversion front end

package forth_pkg;

    // data path and text buffer sizes
    localparam int dsz = 32;                    // converted value width
    localparam int asz = 8;                     // 256-byte text buffer

    // converter FSM
    typedef enum logic [1:0] {
        ini,                                    // wait for enable, sign check
        mem,                                    // wait out buffer read latency
        acc                                     // decode digit, accumulate
    } atoi_state;

    // token scanner FSM
    typedef enum logic [1:0] {
        idle,                                   // wait for start strobe
        fetch,                                  // address issued, data next cycle
        skip,                                   // test byte, step past spaces
        conv                                    // converter running
    } scan_state;

    // characters with special meaning
    localparam logic [7:0] ch_space = 8'h20;    // ' '
    localparam logic [7:0] ch_minus = 8'h2d;    // '-'
    localparam logic [7:0] ch_nul   = 8'h00;    // end of line

endpackage
